// File: source/breaker_pkg.sv
package breaker_pkg;

        // Coded block layout: sync header in the two top bits, payload below.
        localparam int NB_CODED_BLOCK = 66;
        localparam int NB_PAYLOAD     = 64;
        localparam int NB_SYNC        = 2;
        localparam int NB_BLOCK_TYPE  = 8;
        localparam int NB_CTRL_DATA   = NB_PAYLOAD - NB_BLOCK_TYPE;

        // Error schedule limits and counter widths.
        localparam int MAX_ERR_BURST  = 200;
        localparam int MAX_ERR_PERIOD = 400;
        localparam int MAX_ERR_REPEAT = 100;
        localparam int NB_BURST_CNT   = $clog2(MAX_ERR_BURST);
        localparam int NB_PERIOD_CNT  = $clog2(MAX_ERR_PERIOD);
        localparam int NB_REPEAT_CNT  = $clog2(MAX_ERR_REPEAT);

        // One-hot injection modes.
        localparam int N_MODES = 4;
        localparam logic [N_MODES-1:0] MODE_ALIN = 4'b0001;
        localparam logic [N_MODES-1:0] MODE_CTRL = 4'b0010;
        localparam logic [N_MODES-1:0] MODE_DATA = 4'b0100;
        localparam logic [N_MODES-1:0] MODE_ALL  = 4'b1000;

        // Sync header codes.
        localparam logic [NB_SYNC-1:0] SYNC_DATA = 2'b01;
        localparam logic [NB_SYNC-1:0] SYNC_CTRL = 2'b10;

        // Block class codes as seen by the aligner.
        localparam int NB_CLASS = 2;
        localparam logic [NB_CLASS-1:0] CLASS_OTHER = 2'b00;
        localparam logic [NB_CLASS-1:0] CLASS_DATA  = 2'b01;
        localparam logic [NB_CLASS-1:0] CLASS_CTRL  = 2'b10;
        localparam logic [NB_CLASS-1:0] CLASS_ALIN  = 2'b11;

        typedef struct packed
        {
                logic [NB_BLOCK_TYPE-1:0] block_type;
                logic [NB_CTRL_DATA-1:0]  ctrl_payload;
        } ctrl_word_t;

        // Payload seen either as plain data or as a control word.
        typedef union packed
        {
                logic [NB_PAYLOAD-1:0] data_word;
                ctrl_word_t            ctrl_word;
        } payload_u;

endpackage

// File: source/block_classifier.sv
`timescale 1ns/1ps

module block_classifier
(
        input  logic                                    i_clock,
        input  logic                                    i_rst,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [breaker_pkg::NB_CODED_BLOCK-1:0]  i_data,
        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [breaker_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic [breaker_pkg::NB_CLASS-1:0]        o_class
);

        import breaker_pkg::*;

        logic [NB_SYNC-1:0]  sync;
        logic [NB_CLASS-1:0] blk_class;

        assign sync = i_data[NB_CODED_BLOCK-1 -: NB_SYNC];

        // Tagged blocks are alignment markers whatever their header.
        always_comb
        begin
                if (i_aligner_tag)
                begin
                        blk_class = CLASS_ALIN;
                end
                else
                begin
                        case (sync)
                                SYNC_CTRL: blk_class = CLASS_CTRL;
                                SYNC_DATA: blk_class = CLASS_DATA;
                                default:   blk_class = CLASS_OTHER;
                        endcase
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_rst)
                begin
                        o_valid <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clock)
        begin
                o_data        <= i_data;
                o_aligner_tag <= i_aligner_tag;
                o_class       <= blk_class;
        end

        // Class and tag must leave the stage together.
        a_alin_needs_tag: assert property (@(posedge i_clock) disable iff (i_rst)
                o_valid |-> !((o_class == CLASS_ALIN) && !o_aligner_tag));

endmodule

// File: source/error_scheduler.sv
`timescale 1ns/1ps

module error_scheduler
(
        input  logic                                    i_clock,
        input  logic                                    i_rst,
        input  logic                                    i_valid,
        input  logic                                    i_rf_update,
        input  logic [breaker_pkg::NB_BURST_CNT-1:0]    i_rf_error_burst,
        input  logic [breaker_pkg::NB_PERIOD_CNT-1:0]   i_rf_error_period,
        input  logic [breaker_pkg::NB_REPEAT_CNT-1:0]   i_rf_error_repeat,
        output logic                                    o_inject
);

        import breaker_pkg::*;

        logic [NB_BURST_CNT-1:0]  burst_q;
        logic [NB_PERIOD_CNT-1:0] period_q;
        logic [NB_REPEAT_CNT-1:0] repeat_q;
        logic [NB_PERIOD_CNT-1:0] index_q;
        logic [NB_REPEAT_CNT-1:0] period_cnt_q;

        logic [NB_BURST_CNT-1:0]  cur_burst;
        logic [NB_PERIOD_CNT-1:0] cur_period;
        logic [NB_REPEAT_CNT-1:0] cur_repeat;
        logic [NB_PERIOD_CNT-1:0] cur_index;
        logic [NB_REPEAT_CNT-1:0] cur_period_cnt;
        logic [NB_PERIOD_CNT-1:0] index_inc;
        logic                     mark;

        // An update applies to the block of the same cycle, from k = 0.
        assign cur_burst      = i_rf_update ? i_rf_error_burst  : burst_q;
        assign cur_period     = i_rf_update ? i_rf_error_period : period_q;
        assign cur_repeat     = i_rf_update ? i_rf_error_repeat : repeat_q;
        assign cur_index      = i_rf_update ? '0 : index_q;
        assign cur_period_cnt = i_rf_update ? '0 : period_cnt_q;

        assign index_inc = cur_index + NB_PERIOD_CNT'(1);

        // Index below both burst and period covers the min rule and P = 0.
        assign mark = i_valid
                   && (cur_index < NB_PERIOD_CNT'(cur_burst))
                   && (cur_index < cur_period)
                   && (cur_period_cnt < cur_repeat);

        always_ff @(posedge i_clock)
        begin
                if (i_rst)
                begin
                        burst_q      <= '0;
                        period_q     <= '0;
                        repeat_q     <= '0;
                        index_q      <= '0;
                        period_cnt_q <= '0;
                        o_inject     <= 1'b0;
                end
                else
                begin
                        burst_q  <= cur_burst;
                        period_q <= cur_period;
                        repeat_q <= cur_repeat;
                        if (i_valid)
                        begin
                                // With P = 0 the index stays parked at zero.
                                if (index_inc >= cur_period)
                                begin
                                        index_q <= '0;
                                        if (cur_period_cnt < cur_repeat)
                                        begin
                                                period_cnt_q <= cur_period_cnt
                                                                + NB_REPEAT_CNT'(1);
                                        end
                                        else
                                        begin
                                                period_cnt_q <= cur_period_cnt;
                                        end
                                end
                                else
                                begin
                                        index_q      <= index_inc;
                                        period_cnt_q <= cur_period_cnt;
                                end
                        end
                        else
                        begin
                                index_q      <= cur_index;
                                period_cnt_q <= cur_period_cnt;
                        end
                        o_inject <= mark;
                end
        end

        a_index_in_period: assert property (@(posedge i_clock) disable iff (i_rst)
                (period_q != '0) |-> (index_q < period_q));

        // Idle cycles never produce a mark one cycle later.
        a_no_inject_on_gap: assert property (@(posedge i_clock) disable iff (i_rst)
                !i_valid |=> !o_inject);

endmodule

// File: source/payload_corruptor.sv
`timescale 1ns/1ps

module payload_corruptor
(
        input  logic                                    i_clock,
        input  logic                                    i_rst,
        input  logic                                    i_valid,
        input  logic                                    i_rf_update,
        input  logic [breaker_pkg::N_MODES-1:0]         i_rf_mode,
        input  logic [breaker_pkg::NB_PAYLOAD-1:0]      i_rf_error_mask,
        input  logic                                    i_inject,
        input  logic [breaker_pkg::NB_CLASS-1:0]        i_class,
        input  logic                                    i_aligner_tag,
        input  logic [breaker_pkg::NB_CODED_BLOCK-1:0]  i_data,
        output logic                                    o_valid,
        output logic                                    o_aligner_tag,
        output logic [breaker_pkg::NB_CODED_BLOCK-1:0]  o_data
);

        import breaker_pkg::*;

        logic [N_MODES-1:0]    mode_q;
        logic [NB_PAYLOAD-1:0] mask_q;
        logic                  class_hit;
        payload_u              payload_in;
        payload_u              payload_out;

        assign payload_in = i_data[NB_PAYLOAD-1:0];

        always_comb
        begin
                case (mode_q)
                        MODE_ALIN: class_hit = (i_class == CLASS_ALIN);
                        MODE_CTRL: class_hit = (i_class == CLASS_CTRL);
                        MODE_DATA: class_hit = (i_class == CLASS_DATA);
                        MODE_ALL:  class_hit = 1'b1;
                        default:   class_hit = 1'b0;
                endcase
        end

        // Control blocks keep their block type byte.
        always_comb
        begin
                payload_out = payload_in;
                if (i_inject && class_hit)
                begin
                        if (i_class == CLASS_CTRL)
                        begin
                                payload_out.ctrl_word.ctrl_payload =
                                        payload_in.ctrl_word.ctrl_payload
                                        ^ mask_q[NB_CTRL_DATA-1:0];
                        end
                        else
                        begin
                                payload_out.data_word = payload_in.data_word ^ mask_q;
                        end
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_rst)
                begin
                        mode_q  <= '0;
                        mask_q  <= '0;
                        o_valid <= 1'b0;
                end
                else
                begin
                        if (i_rf_update)
                        begin
                                mode_q <= i_rf_mode;
                                mask_q <= i_rf_error_mask;
                        end
                        o_valid <= i_valid;
                end
        end

        always_ff @(posedge i_clock)
        begin
                o_data        <= {i_data[NB_CODED_BLOCK-1 -: NB_SYNC], payload_out};
                o_aligner_tag <= i_aligner_tag;
        end

        a_sync_kept: assert property (@(posedge i_clock) disable iff (i_rst)
                i_valid |=> (o_data[NB_CODED_BLOCK-1 -: NB_SYNC]
                             == $past(i_data[NB_CODED_BLOCK-1 -: NB_SYNC])));

endmodule

// File: source/payload_breaker.sv
`timescale 1ns/1ps

module payload_breaker
(
        input  logic                                    i_clock,
        input  logic                                    i_rst,
        input  logic                                    i_valid,
        input  logic                                    i_aligner_tag,
        input  logic [breaker_pkg::NB_CODED_BLOCK-1:0]  i_data,
        input  logic [breaker_pkg::N_MODES-1:0]         i_rf_mode,
        input  logic [breaker_pkg::NB_PAYLOAD-1:0]      i_rf_error_mask,
        input  logic [breaker_pkg::NB_BURST_CNT-1:0]    i_rf_error_burst,
        input  logic [breaker_pkg::NB_PERIOD_CNT-1:0]   i_rf_error_period,
        input  logic [breaker_pkg::NB_REPEAT_CNT-1:0]   i_rf_error_repeat,
        input  logic                                    i_rf_update,
        output logic                                    o_valid,
        output logic [breaker_pkg::NB_CODED_BLOCK-1:0]  o_data,
        output logic                                    o_aligner_tag
);

        import breaker_pkg::*;

        logic                      s1_valid;
        logic [NB_CODED_BLOCK-1:0] s1_data;
        logic                      s1_tag;
        logic [NB_CLASS-1:0]       s1_class;
        logic                      s1_inject;

        block_classifier u_block_classifier
        (
                .i_clock        (i_clock),
                .i_rst          (i_rst),
                .i_valid        (i_valid),
                .i_aligner_tag  (i_aligner_tag),
                .i_data         (i_data),
                .o_valid        (s1_valid),
                .o_aligner_tag  (s1_tag),
                .o_data         (s1_data),
                .o_class        (s1_class)
        );

        // Works on the input cycle so its mark lines up with stage 1.
        error_scheduler u_error_scheduler
        (
                .i_clock            (i_clock),
                .i_rst              (i_rst),
                .i_valid            (i_valid),
                .i_rf_update        (i_rf_update),
                .i_rf_error_burst   (i_rf_error_burst),
                .i_rf_error_period  (i_rf_error_period),
                .i_rf_error_repeat  (i_rf_error_repeat),
                .o_inject           (s1_inject)
        );

        payload_corruptor u_payload_corruptor
        (
                .i_clock          (i_clock),
                .i_rst            (i_rst),
                .i_valid          (s1_valid),
                .i_rf_update      (i_rf_update),
                .i_rf_mode        (i_rf_mode),
                .i_rf_error_mask  (i_rf_error_mask),
                .i_inject         (s1_inject),
                .i_class          (s1_class),
                .i_aligner_tag    (s1_tag),
                .i_data           (s1_data),
                .o_valid          (o_valid),
                .o_aligner_tag    (o_aligner_tag),
                .o_data           (o_data)
        );

endmodule

// File: include/tb_breaker_model.svh
`ifndef TB_BREAKER_MODEL_SVH
`define TB_BREAKER_MODEL_SVH

localparam logic [31:0] LFSR_TAPS = 32'hb4bcd35c;

// Reference copy of the captured configuration and schedule position.
int                   mdl_burst;
int                   mdl_period;
int                   mdl_repeat;
int                   mdl_index;
int                   mdl_period_cnt;
logic [N_MODES-1:0]   mdl_mode;
logic [NB_PAYLOAD-1:0] mdl_mask;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
endfunction

// One LFSR step per bit taken, first bit ends up most significant.
function automatic logic [NB_CODED_BLOCK-1:0] lfsr_take(inout logic [31:0] state,
                                                        input int n_bits);
        logic [NB_CODED_BLOCK-1:0] bits;
        bits = '0;
        for (int i = 0; i < n_bits; i++)
        begin
                bits  = {bits[NB_CODED_BLOCK-2:0], state[0]};
                state = lfsr_next(state);
        end
        return bits;
endfunction

function automatic void model_update(input int b, input int p, input int r,
                                     input logic [N_MODES-1:0] mode,
                                     input logic [NB_PAYLOAD-1:0] mask);
        mdl_burst      = b;
        mdl_period     = p;
        mdl_repeat     = r;
        mdl_mode       = mode;
        mdl_mask       = mask;
        mdl_index      = 0;
        mdl_period_cnt = 0;
endfunction

// Marks the current block and advances the schedule by one valid block.
function automatic logic model_mark();
        logic mark;
        mark = (mdl_index < mdl_burst) && (mdl_index < mdl_period)
               && (mdl_period_cnt < mdl_repeat);
        if (mdl_period > 0)
        begin
                mdl_index = mdl_index + 1;
                if (mdl_index >= mdl_period)
                begin
                        mdl_index      = 0;
                        mdl_period_cnt = mdl_period_cnt + 1;
                end
        end
        return mark;
endfunction

function automatic logic [NB_CODED_BLOCK-1:0] model_expect(input logic tag,
                                                           input logic [NB_CODED_BLOCK-1:0] blk);
        logic [NB_SYNC-1:0] sync;
        logic               hit;
        payload_u           pl;
        sync = blk[NB_CODED_BLOCK-1 -: NB_SYNC];
        pl   = blk[NB_PAYLOAD-1:0];
        hit  = (mdl_mode == MODE_ALL)
               || ((mdl_mode == MODE_ALIN) && tag)
               || ((mdl_mode == MODE_CTRL) && !tag && (sync == SYNC_CTRL))
               || ((mdl_mode == MODE_DATA) && !tag && (sync == SYNC_DATA));
        if (model_mark() && hit)
        begin
                if (!tag && (sync == SYNC_CTRL))
                        pl.ctrl_word.ctrl_payload ^= mdl_mask[NB_CTRL_DATA-1:0];
                else
                        pl.data_word ^= mdl_mask;
        end
        return {sync, pl};
endfunction

`endif

// File: test/tb_payload_breaker.sv
`timescale 1ns/1ps

module tb_payload_breaker;

        import breaker_pkg::*;

        `include "tb_breaker_model.svh"

        logic                      i_clock;
        logic                      i_rst;
        logic                      i_valid;
        logic                      i_aligner_tag;
        logic [NB_CODED_BLOCK-1:0] i_data;
        logic [N_MODES-1:0]        i_rf_mode;
        logic [NB_PAYLOAD-1:0]     i_rf_error_mask;
        logic [NB_BURST_CNT-1:0]   i_rf_error_burst;
        logic [NB_PERIOD_CNT-1:0]  i_rf_error_period;
        logic [NB_REPEAT_CNT-1:0]  i_rf_error_repeat;
        logic                      i_rf_update;
        logic                      o_valid;
        logic [NB_CODED_BLOCK-1:0] o_data;
        logic                      o_aligner_tag;

        logic [31:0]               lfsr_state;
        logic [NB_CODED_BLOCK-1:0] exp_data_q[$];
        logic                      exp_tag_q[$];
        time                       sent_time_q[$];
        logic [NB_CODED_BLOCK-1:0] exp_data;
        logic                      exp_tag;
        time                       sent_time;
        int                        cmp_errors = 0;
        int                        seq_errors = 0;
        int                        n_checked = 0;
        int                        n_tests = 0;
        int                        test_base = 0;

        payload_breaker DUT
        (
                .i_clock            (i_clock),
                .i_rst              (i_rst),
                .i_valid            (i_valid),
                .i_aligner_tag      (i_aligner_tag),
                .i_data             (i_data),
                .i_rf_mode          (i_rf_mode),
                .i_rf_error_mask    (i_rf_error_mask),
                .i_rf_error_burst   (i_rf_error_burst),
                .i_rf_error_period  (i_rf_error_period),
                .i_rf_error_repeat  (i_rf_error_repeat),
                .i_rf_update        (i_rf_update),
                .o_valid            (o_valid),
                .o_data             (o_data),
                .o_aligner_tag      (o_aligner_tag)
        );

        initial
        begin
                i_clock = 1'b0;
                forever #5 i_clock = ~i_clock;
        end

        // Outputs are sampled on the falling edge, half a cycle after they change.
        always @(negedge i_clock)
        begin
                if (o_valid === 1'b1)
                begin
                        if (exp_data_q.size() == 0)
                        begin
                                $display("Unexpected output block at %0t, none was pending",
                                         $time);
                                cmp_errors++;
                        end
                        else
                        begin
                                exp_data  = exp_data_q.pop_front();
                                exp_tag   = exp_tag_q.pop_front();
                                sent_time = sent_time_q.pop_front();
                                n_checked++;
                                if ((o_data !== exp_data) || (o_aligner_tag !== exp_tag))
                                begin
                                        $display("Mismatch at %0t: got %h tag %b, exp %h tag %b",
                                                 $time, o_data, o_aligner_tag, exp_data, exp_tag);
                                        cmp_errors++;
                                end
                                // Sent on one edge, out two edges later, seen at the negedge.
                                if (($time - sent_time) != 25)
                                begin
                                        $display("Mismatch at %0t: wrong latency, sent at %0t",
                                                 $time, sent_time);
                                        cmp_errors++;
                                end
                        end
                end
        end

        task automatic idle_cycle();
                @(posedge i_clock);
                i_valid     <= 1'b0;
                i_rf_update <= 1'b0;
        endtask

        task automatic send_block(input logic tag, input logic [NB_CODED_BLOCK-1:0] blk);
                @(posedge i_clock);
                i_valid       <= 1'b1;
                i_aligner_tag <= tag;
                i_data        <= blk;
                i_rf_update   <= 1'b0;
                exp_data_q.push_back(model_expect(tag, blk));
                exp_tag_q.push_back(tag);
                sent_time_q.push_back($time);
        endtask

        task automatic send_random(input int n_blocks, input logic with_gaps);
                logic [NB_CODED_BLOCK-1:0] rnd;
                logic                      tag;
                int                        gap;
                for (int i = 0; i < n_blocks; i++)
                begin
                        rnd = lfsr_take(lfsr_state, 2);
                        if (with_gaps && (rnd[1:0] == 2'b00))
                        begin
                                rnd = lfsr_take(lfsr_state, 2);
                                gap = int'(rnd[1:0]) + 1;
                                repeat (gap) idle_cycle();
                        end
                        rnd = lfsr_take(lfsr_state, 2);
                        tag = (rnd[1:0] == 2'b00);
                        rnd = lfsr_take(lfsr_state, NB_CODED_BLOCK);
                        send_block(tag, rnd);
                end
                idle_cycle();
        endtask

        function automatic logic [NB_PAYLOAD-1:0] random_mask();
                logic [NB_CODED_BLOCK-1:0] rnd;
                rnd = lfsr_take(lfsr_state, NB_PAYLOAD);
                return rnd[NB_PAYLOAD-1:0];
        endfunction

        task automatic apply_update(input int b, input int p, input int r,
                                    input logic [N_MODES-1:0] mode,
                                    input logic [NB_PAYLOAD-1:0] mask);
                // Stage 2 must be empty before mode and mask change.
                idle_cycle();
                idle_cycle();
                @(posedge i_clock);
                i_valid           <= 1'b0;
                i_rf_update       <= 1'b1;
                i_rf_mode         <= mode;
                i_rf_error_mask   <= mask;
                i_rf_error_burst  <= NB_BURST_CNT'(b);
                i_rf_error_period <= NB_PERIOD_CNT'(p);
                i_rf_error_repeat <= NB_REPEAT_CNT'(r);
                model_update(b, p, r, mode, mask);
                idle_cycle();
        endtask

        task automatic wait_drain();
                int cycles;
                cycles = 0;
                while ((exp_data_q.size() != 0) && (cycles < 20))
                begin
                        @(posedge i_clock);
                        cycles++;
                end
                if (exp_data_q.size() != 0)
                begin
                        $display("Timeout at %0t: %0d expected blocks never came out",
                                 $time, exp_data_q.size());
                        seq_errors++;
                        exp_data_q.delete();
                        exp_tag_q.delete();
                        sent_time_q.delete();
                end
        endtask

        task automatic report_test(input string name);
                int errs;
                wait_drain();
                n_tests++;
                errs = cmp_errors + seq_errors - test_base;
                if (errs == 0)
                        $display("Test %0d (%s): passed", n_tests, name);
                else
                        $display("Test %0d (%s): %0d errors", n_tests, name, errs);
                test_base = cmp_errors + seq_errors;
        endtask

        initial
        begin
                i_rst             <= 1'b1;
                i_valid           <= 1'b0;
                i_aligner_tag     <= 1'b0;
                i_data            <= '0;
                // Live register levels that no update has captured yet.
                i_rf_mode         <= MODE_ALL;
                i_rf_error_mask   <= '1;
                i_rf_error_burst  <= NB_BURST_CNT'(5);
                i_rf_error_period <= NB_PERIOD_CNT'(8);
                i_rf_error_repeat <= NB_REPEAT_CNT'(10);
                i_rf_update       <= 1'b0;
                lfsr_state = 32'heafbb7c6;
                model_update(0, 0, 0, '0, '0);
                repeat (3) @(posedge i_clock);
                i_rst <= 1'b0;

                send_random(40, 1'b1);
                report_test("no update, blocks pass clean");

                apply_update(10, 15, 4, MODE_ALL, 64'hff00ff00ff00ff00);
                send_random(75, 1'b0);
                report_test("mode all, burst 10 of 15, 4 periods");

                apply_update(10, 15, 4, MODE_ALL, 64'hff00ff00ff00ff00);
                send_random(75, 1'b1);
                apply_update(1, 7, 3, MODE_ALL, random_mask());
                send_random(30, 1'b1);
                apply_update(20, 5, 2, MODE_ALL, random_mask());
                send_random(20, 1'b1);
                report_test("valid gaps, burst 1, burst above period");

                apply_update(3, 4, 20, MODE_CTRL, random_mask());
                send_random(80, 1'b1);
                report_test("control mode keeps block type");

                apply_update(5, 6, 10, MODE_DATA, random_mask());
                send_random(60, 1'b1);
                apply_update(2, 2, 50, MODE_ALIN, random_mask());
                send_random(60, 1'b1);
                apply_update(8, 8, 10, 4'b0011, random_mask());
                send_random(30, 1'b1);
                report_test("data, alignment and invalid modes");

                apply_update(4, 9, 5, MODE_ALL, random_mask());
                send_random(13, 1'b1);
                apply_update(6, 8, 2, MODE_ALL, random_mask());
                send_random(30, 1'b1);
                apply_update(5, 0, 10, MODE_ALL, random_mask());
                send_random(25, 1'b1);
                report_test("restart in mid-schedule, zero period");

                $display("%0d tests, %0d blocks checked, %0d errors",
                         n_tests, n_checked, cmp_errors + seq_errors);
                if ((cmp_errors + seq_errors) == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

endmodule

// File: src.f
+incdir+include
source/breaker_pkg.sv
source/block_classifier.sv
source/error_scheduler.sv
source/payload_corruptor.sv
source/payload_breaker.sv
test/tb_payload_breaker.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
        -f src.f \
        --top-module tb_payload_breaker \
        -o sim_payload_breaker

./obj_dir/sim_payload_breaker | tee sim.log

if grep -q "Test failed" sim.log; then
        echo "Simulation reported failure"
        exit 1
fi

if ! grep -q "Test completed successfully" sim.log; then
        echo "Simulation ended without a result"
        exit 1
fi

echo "Simulation passed"
